// File: Makefile
# Verilator build and run for the mini SoC testbench
TOP := tb_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f flist.f --top-module $(TOP) -Mdir obj_dir -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "\*\*\* TEST PASSED \*\*\*" sim.log

lint:
	verilator --lint-only common/soc_pkg.sv hw/boot_rom.sv hw/scratch_ram.sv \
		hw/debug_holdoff.sv hw/timer/rtc_timer.sv hw/bus_port.sv hw/mini_soc_top.sv \
		--top-module mini_soc_top

clean:
	rm -rf obj_dir sim.log

// File: common/soc_pkg.sv
/*
  Shared types and address map of the debug-and-boot subsystem.
  All addresses are byte addresses on a 16-bit host bus with 32-bit data.
  The RAM region length depends on the top-level RAM_WORDS parameter and
  is therefore not fixed here. ROM_IMAGE must hold exactly ROM_WORDS words.
*/
package soc_pkg;

  // ------------------------------
  // widths and bus types
  // ------------------------------
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [STRB_W-1:0] strb_t;

  // command that travels with a host request
  typedef struct packed {
    logic  write;
    addr_t addr;
    data_t wdata;
    strb_t strb;
  } bus_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  // ------------------------------
  // address map
  // ------------------------------
  localparam addr_t       ROM_BASE  = 16'h0000;
  localparam int unsigned ROM_WORDS = 8;

  // small boot stub, ends in a jump-to-self
  localparam data_t ROM_IMAGE [ROM_WORDS] = '{
    32'h0000_1297, 32'h0002_8293, 32'h0000_0513, 32'h0000_0593,
    32'h0010_0613, 32'h00c5_2023, 32'h1050_0073, 32'h0000_006f
  };

  localparam addr_t RAM_BASE        = 16'h1000;
  localparam addr_t TIMER_BASE      = 16'h2000;
  localparam addr_t TIMER_MTIME_OFS = 16'h0000;
  localparam addr_t TIMER_CMP_OFS   = 16'h0004;

  // ------------------------------
  // decode and handshake states
  // ------------------------------
  typedef enum logic [1:0] {ROM, RAM, TIMER, NONE} target_e;

  typedef enum logic [1:0] {IDLE, ACCESS, RESPOND, RELEASE} port_state_e;

endpackage

// File: flist.f
common/soc_pkg.sv
hw/boot_rom.sv
hw/scratch_ram.sv
hw/debug_holdoff.sv
hw/timer/rtc_timer.sv
hw/bus_port.sv
hw/mini_soc_top.sv
tb/tb_top.sv

// File: hw/boot_rom.sv
/*
  Boot ROM built from the package image.
  Only the word index bits of the address are looked at; the port
  guarantees the address lies inside the ROM region.
*/
`timescale 1ns/1ps

module boot_rom (
  input  logic           clk_i,
  input  logic           rom_sel_i,
  input  soc_pkg::addr_t rom_addr_i,
  output soc_pkg::data_t rom_rdata_o
);

  localparam int unsigned ROM_AW = $clog2(soc_pkg::ROM_WORDS);

  logic [ROM_AW-1:0] word_idx;

  assign word_idx = rom_addr_i[ROM_AW+1:2];

  // one cycle from select to data
  always_ff @(posedge clk_i) begin
    if (rom_sel_i) begin
      rom_rdata_o <= soc_pkg::ROM_IMAGE[word_idx];
    end
  end

endmodule

// File: hw/bus_port.sv
/*
  Host port with a four-phase req/ack handshake.
  The command is sampled on the edge that first sees req high and must stay
  stable until ack. Errors (unmapped address, ROM write, bad timer offset)
  select no target and return zero data. Writes always return zero data.
  ack stays high until req is seen low, so a new request waits for that.
*/
`timescale 1ns/1ps

module bus_port #(
  parameter int unsigned RAM_WORDS = 64
) (
  input  logic              clk_i,
  input  logic              ndmreset_n,
  input  logic              bus_req_i,
  input  soc_pkg::bus_req_t bus_cmd_i,
  output logic              bus_ack_o,
  output soc_pkg::bus_rsp_t bus_rsp_o,
  output logic              rom_sel_o,
  output logic              ram_sel_o,
  output logic              tmr_sel_o,
  output soc_pkg::bus_req_t tgt_cmd_o,
  input  soc_pkg::data_t    rom_rdata_i,
  input  soc_pkg::data_t    ram_rdata_i,
  input  soc_pkg::data_t    tmr_rdata_i
);

  localparam logic [31:0] ROM_LO   = 32'(soc_pkg::ROM_BASE);
  localparam logic [31:0] ROM_SIZE = 32'(soc_pkg::ROM_WORDS * 4);
  localparam logic [31:0] RAM_LO   = 32'(soc_pkg::RAM_BASE);
  localparam logic [31:0] RAM_SIZE = 32'(RAM_WORDS * 4);
  localparam soc_pkg::addr_t TMR_MTIME = soc_pkg::TIMER_BASE + soc_pkg::TIMER_MTIME_OFS;
  localparam soc_pkg::addr_t TMR_CMP   = soc_pkg::TIMER_BASE + soc_pkg::TIMER_CMP_OFS;

  soc_pkg::port_state_e state_q;
  soc_pkg::target_e     tgt_d;
  soc_pkg::target_e     tgt_q;
  soc_pkg::bus_req_t    cmd_q;
  soc_pkg::bus_rsp_t    rsp_d;
  soc_pkg::bus_rsp_t    rsp_q;
  logic                 ack_q;
  logic [31:0]          addr_ext;

  // ------------------------------
  // address decode
  // ------------------------------
  assign addr_ext = {16'b0, bus_cmd_i.addr};

  // unsigned offset compare covers both region bounds at once
  always_comb begin
    tgt_d = soc_pkg::NONE;
    if ((addr_ext - ROM_LO) < ROM_SIZE) begin
      if (!bus_cmd_i.write) begin
        tgt_d = soc_pkg::ROM;
      end
    end else if ((addr_ext - RAM_LO) < RAM_SIZE) begin
      tgt_d = soc_pkg::RAM;
    end else if (bus_cmd_i.addr == TMR_MTIME || bus_cmd_i.addr == TMR_CMP) begin
      tgt_d = soc_pkg::TIMER;
    end
  end

  // ------------------------------
  // handshake FSM
  // ------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      state_q <= soc_pkg::IDLE;
      tgt_q   <= soc_pkg::NONE;
      ack_q   <= 1'b0;
      rsp_q   <= '0;
    end else begin
      case (state_q)
        soc_pkg::IDLE: begin
          if (bus_req_i) begin
            state_q <= soc_pkg::ACCESS;
            tgt_q   <= tgt_d;
          end
        end
        soc_pkg::ACCESS: begin
          state_q <= soc_pkg::RESPOND;
        end
        soc_pkg::RESPOND: begin
          state_q <= soc_pkg::RELEASE;
          ack_q   <= 1'b1;
          rsp_q   <= rsp_d;
        end
        soc_pkg::RELEASE: begin
          // hold ack and response until the host lets go
          if (!bus_req_i) begin
            state_q <= soc_pkg::IDLE;
            ack_q   <= 1'b0;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == soc_pkg::IDLE && bus_req_i) begin
      cmd_q <= bus_cmd_i;
    end
  end

  // response collection
  always_comb begin
    rsp_d.err = (tgt_q == soc_pkg::NONE);
    case (tgt_q)
      soc_pkg::ROM:   rsp_d.rdata = rom_rdata_i;
      soc_pkg::RAM:   rsp_d.rdata = ram_rdata_i;
      soc_pkg::TIMER: rsp_d.rdata = tmr_rdata_i;
      default:        rsp_d.rdata = '0;
    endcase
    if (cmd_q.write) begin
      rsp_d.rdata = '0;
    end
  end

  assign rom_sel_o = (state_q == soc_pkg::ACCESS) && (tgt_q == soc_pkg::ROM);
  assign ram_sel_o = (state_q == soc_pkg::ACCESS) && (tgt_q == soc_pkg::RAM);
  assign tmr_sel_o = (state_q == soc_pkg::ACCESS) && (tgt_q == soc_pkg::TIMER);
  assign tgt_cmd_o = cmd_q;
  assign bus_ack_o = ack_q;
  assign bus_rsp_o = rsp_q;

endmodule

// File: hw/debug_holdoff.sv
/*
  Blocks debug requests for HOLDOFF_CYCLES clock cycles after reset, so
  boot code runs before the first halt. The output follows the input
  combinationally once the countdown has reached zero.
*/
`timescale 1ns/1ps

module debug_holdoff #(
  parameter int unsigned HOLDOFF_CYCLES = 500
) (
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic debug_req_i,
  output logic debug_req_o
);

  localparam int unsigned CNT_W = $clog2(HOLDOFF_CYCLES + 1);

  typedef logic [CNT_W-1:0] cnt_t;

  cnt_t cnt_q;

  // saturating countdown
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q <= cnt_t'(HOLDOFF_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - cnt_t'(1);
    end
  end

  assign debug_req_o = (cnt_q == '0) ? debug_req_i : 1'b0;

endmodule

// File: hw/mini_soc_top.sv
/*
  Debug-and-boot subsystem top: host port, boot ROM, scratchpad RAM,
  machine timer and debug-request hold-off. Single clock domain, one
  asynchronous active-low reset. rtc_i and debug_req_i may be asynchronous
  to clk_i; rtc_i is synchronized inside the timer.
*/
`timescale 1ns/1ps

module mini_soc_top #(
  parameter int unsigned RAM_WORDS      = 64,
  parameter int unsigned HOLDOFF_CYCLES = 500
) (
  input  logic              clk_i,
  input  logic              ndmreset_n,
  input  logic              rtc_i,
  input  logic              bus_req_i,
  input  soc_pkg::bus_req_t bus_cmd_i,
  output logic              bus_ack_o,
  output soc_pkg::bus_rsp_t bus_rsp_o,
  input  logic              debug_req_i,
  output logic              debug_req_o,
  output logic              timer_irq_o
);

  logic              rom_sel;
  logic              ram_sel;
  logic              tmr_sel;
  soc_pkg::bus_req_t tgt_cmd;
  soc_pkg::data_t    rom_rdata;
  soc_pkg::data_t    ram_rdata;
  soc_pkg::data_t    tmr_rdata;

  bus_port #(
    .RAM_WORDS   ( RAM_WORDS   )
  ) i_bus_port (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .bus_req_i   ( bus_req_i   ),
    .bus_cmd_i   ( bus_cmd_i   ),
    .bus_ack_o   ( bus_ack_o   ),
    .bus_rsp_o   ( bus_rsp_o   ),
    .rom_sel_o   ( rom_sel     ),
    .ram_sel_o   ( ram_sel     ),
    .tmr_sel_o   ( tmr_sel     ),
    .tgt_cmd_o   ( tgt_cmd     ),
    .rom_rdata_i ( rom_rdata   ),
    .ram_rdata_i ( ram_rdata   ),
    .tmr_rdata_i ( tmr_rdata   )
  );

  boot_rom i_boot_rom (
    .clk_i       ( clk_i        ),
    .rom_sel_i   ( rom_sel      ),
    .rom_addr_i  ( tgt_cmd.addr ),
    .rom_rdata_o ( rom_rdata    )
  );

  scratch_ram #(
    .RAM_WORDS   ( RAM_WORDS )
  ) i_scratch_ram (
    .clk_i       ( clk_i     ),
    .ram_sel_i   ( ram_sel   ),
    .ram_cmd_i   ( tgt_cmd   ),
    .ram_rdata_o ( ram_rdata )
  );

  rtc_timer i_rtc_timer (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .tmr_sel_i   ( tmr_sel     ),
    .tmr_cmd_i   ( tgt_cmd     ),
    .tmr_rdata_o ( tmr_rdata   ),
    .timer_irq_o ( timer_irq_o )
  );

  // boot window before external debug can halt
  debug_holdoff #(
    .HOLDOFF_CYCLES ( HOLDOFF_CYCLES )
  ) i_debug_holdoff (
    .clk_i          ( clk_i          ),
    .ndmreset_n     ( ndmreset_n     ),
    .debug_req_i    ( debug_req_i    ),
    .debug_req_o    ( debug_req_o    )
  );

endmodule

// File: hw/scratch_ram.sv
/*
  Scratchpad RAM of RAM_WORDS 32-bit words with byte strobes.
  RAM_WORDS must be a power of two and at least 2. Contents come up
  undefined after power-on. Read data is registered and only updated on
  a selected read; writes leave it unchanged.
*/
`timescale 1ns/1ps

module scratch_ram #(
  parameter int unsigned RAM_WORDS = 64
) (
  input  logic              clk_i,
  input  logic              ram_sel_i,
  input  soc_pkg::bus_req_t ram_cmd_i,
  output soc_pkg::data_t    ram_rdata_o
);

  localparam int unsigned RAM_AW = $clog2(RAM_WORDS);

  soc_pkg::data_t    mem_q [RAM_WORDS];
  logic [RAM_AW-1:0] word_idx;

  assign word_idx = ram_cmd_i.addr[RAM_AW+1:2];

  always_ff @(posedge clk_i) begin
    if (ram_sel_i) begin
      if (ram_cmd_i.write) begin
        // merge only the strobed byte lanes
        for (int b = 0; b < soc_pkg::STRB_W; b++) begin
          if (ram_cmd_i.strb[b]) begin
            mem_q[word_idx][8*b +: 8] <= ram_cmd_i.wdata[8*b +: 8];
          end
        end
      end else begin
        ram_rdata_o <= mem_q[word_idx];
      end
    end
  end

endmodule

// File: hw/timer/rtc_timer.sv
/*
  Machine timer clocked from clk_i with rtc_i as a sampled time base.
  rtc_i must stay high and low for at least two clk_i cycles each.
  mtime counts every second rtc rising edge and is read only; mtimecmp is
  written as a full word, strobes are ignored. The interrupt is registered
  and stays high as long as mtime >= mtimecmp.
*/
`timescale 1ns/1ps

module rtc_timer (
  input  logic              clk_i,
  input  logic              ndmreset_n,
  input  logic              rtc_i,
  input  logic              tmr_sel_i,
  input  soc_pkg::bus_req_t tmr_cmd_i,
  output soc_pkg::data_t    tmr_rdata_o,
  output logic              timer_irq_o
);

  logic [1:0]     rtc_sync_q;
  logic           rtc_prev_q;
  logic           rtc_rise;
  logic           div_q;
  logic           cmp_sel;
  soc_pkg::data_t mtime_q;
  soc_pkg::data_t mtimecmp_q;
  logic           irq_q;

  // ------------------------------
  // rtc sampling and divide by two
  // ------------------------------
  assign rtc_rise = rtc_sync_q[1] & ~rtc_prev_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q <= '0;
      rtc_prev_q <= 1'b0;
      div_q      <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
      if (rtc_rise) begin
        div_q <= ~div_q;
      end
    end
  end

  // ------------------------------
  // count, compare, interrupt
  // ------------------------------
  assign cmp_sel = tmr_cmd_i.addr[2];

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      irq_q      <= 1'b0;
    end else begin
      // tick on the second edge of each pair
      if (rtc_rise && div_q) begin
        mtime_q <= mtime_q + 32'd1;
      end
      if (tmr_sel_i && tmr_cmd_i.write && cmp_sel) begin
        mtimecmp_q <= tmr_cmd_i.wdata;
      end
      irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  always_ff @(posedge clk_i) begin
    if (tmr_sel_i) begin
      tmr_rdata_o <= cmp_sel ? mtimecmp_q : mtime_q;
    end
  end

  assign timer_irq_o = irq_q;

endmodule

// File: tb/tb_top.sv
/*
  Testbench for mini_soc_top with RAM_WORDS 64 and HOLDOFF_CYCLES 40.
  The main process runs four-phase host accesses, while a monitor checks
  the handshake order and compares each response with the reference model.
  Random values come from a 32-bit LFSR. The run stops at the first error.
*/
`timescale 1ns/1ps

module tb_top;

  localparam int unsigned RAM_WORDS = 64;
  localparam int unsigned HOLDOFF   = 40;

  logic              clk_i;
  logic              ndmreset_n;
  logic              rtc_i;
  logic              bus_req_i;
  soc_pkg::bus_req_t bus_cmd_i;
  logic              bus_ack_o;
  soc_pkg::bus_rsp_t bus_rsp_o;
  logic              debug_req_i;
  logic              debug_req_o;
  logic              timer_irq_o;

  logic [31:0]       lfsr_q;
  soc_pkg::data_t    shadow_ram [RAM_WORDS];
  soc_pkg::data_t    exp_cmp;
  int                rtc_edges;
  soc_pkg::bus_rsp_t exp_q [$];
  logic              ack_prev;
  logic              req_prev;
  soc_pkg::bus_rsp_t rsp_held;

  mini_soc_top #(
    .RAM_WORDS      ( RAM_WORDS ),
    .HOLDOFF_CYCLES ( HOLDOFF   )
  ) dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ------------------------------
  // helpers
  // ------------------------------
  task automatic stop_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_rsp(input soc_pkg::bus_rsp_t exp, input soc_pkg::bus_rsp_t got,
                           input string what);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s, expected data %h err %b, got data %h err %b",
               $time, what, exp.rdata, exp.err, got.rdata, got.err);
      stop_run();
    end
  endtask

  task automatic check_bit(input logic exp, input logic got, input string what);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s, expected %b, got %b", $time, what, exp, got);
      stop_run();
    end
  endtask

  // fibonacci lfsr with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // expected response from the address map, shadow RAM and timer state
  function automatic soc_pkg::bus_rsp_t ref_rsp(input soc_pkg::bus_req_t c);
    soc_pkg::bus_rsp_t r;
    logic [31:0]       a;
    logic [5:0]        idx;
    r   = '0;
    a   = {16'h0, c.addr};
    idx = c.addr[7:2];
    if (a < 32'(soc_pkg::ROM_BASE) + 32'(soc_pkg::ROM_WORDS * 4)) begin
      if (c.write)
        r.err = 1'b1;
      else
        r.rdata = soc_pkg::ROM_IMAGE[c.addr[4:2]];
    end else if (a >= 32'(soc_pkg::RAM_BASE) &&
                 a < 32'(soc_pkg::RAM_BASE) + 32'(RAM_WORDS * 4)) begin
      if (c.write) begin
        for (int b = 0; b < 4; b++)
          if (c.strb[b])
            shadow_ram[idx][8*b +: 8] = c.wdata[8*b +: 8];
      end else begin
        r.rdata = shadow_ram[idx];
      end
    end else if (c.addr == soc_pkg::TIMER_BASE + soc_pkg::TIMER_MTIME_OFS) begin
      if (!c.write)
        r.rdata = soc_pkg::data_t'(rtc_edges / 2);
    end else if (c.addr == soc_pkg::TIMER_BASE + soc_pkg::TIMER_CMP_OFS) begin
      if (c.write)
        exp_cmp = c.wdata;
      else
        r.rdata = exp_cmp;
    end else begin
      r.err = 1'b1;
    end
    return r;
  endfunction

  // one four-phase access with req held 0 to 10 extra cycles
  task automatic bus_access(input logic wr, input soc_pkg::addr_t addr,
                            input soc_pkg::data_t wdata, input soc_pkg::strb_t strb);
    soc_pkg::bus_req_t cmd;
    int                hold;
    int                t;
    cmd  = '{write: wr, addr: addr, wdata: wdata, strb: strb};
    hold = int'(rand_bits(4)) % 11;
    exp_q.push_back(ref_rsp(cmd));
    @(posedge clk_i);
    bus_cmd_i <= cmd;
    bus_req_i <= 1'b1;
    t = 0;
    while (bus_ack_o !== 1'b1) begin
      @(posedge clk_i);
      t++;
      if (t > 20) begin
        $display("timeout: ack never rose for access to address %h", addr);
        stop_run();
      end
    end
    repeat (hold) @(posedge clk_i);
    bus_req_i <= 1'b0;
    t = 0;
    while (bus_ack_o !== 1'b0) begin
      @(posedge clk_i);
      t++;
      if (t > 20) begin
        $display("timeout: ack never fell for access to address %h", addr);
        stop_run();
      end
    end
  endtask

  // one rtc period of 8 clocks with irq still low
  task automatic rtc_cycle();
    @(posedge clk_i);
    rtc_i <= 1'b1;
    rtc_edges++;
    for (int c = 1; c < 8; c++) begin
      @(posedge clk_i);
      if (c == 4)
        rtc_i <= 1'b0;
      check_bit(1'b0, timer_irq_o, "timer irq before compare match");
    end
  endtask

  // ------------------------------
  // handshake monitor and compare
  // ------------------------------
  always @(posedge clk_i) begin
    if (ndmreset_n) begin
      if (bus_ack_o && !ack_prev) begin
        check_bit(1'b1, req_prev, "req high when ack rises");
        if (exp_q.size() == 0) begin
          $display("ack rose with no access outstanding");
          stop_run();
        end
        check_rsp(exp_q.pop_front(), bus_rsp_o, "bus response");
        rsp_held = bus_rsp_o;
      end else if (bus_ack_o && ack_prev) begin
        check_rsp(rsp_held, bus_rsp_o, "response held while ack high");
      end else if (!bus_ack_o && ack_prev) begin
        check_bit(1'b0, req_prev, "req low before ack falls");
      end
    end
    ack_prev = bus_ack_o;
    req_prev = bus_req_i;
  end

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    soc_pkg::addr_t addr;
    soc_pkg::addr_t bad_addr [8];
    int             t;
    int             n;
    lfsr_q      = 32'd82379;
    ndmreset_n  = 1'b0;
    rtc_i       = 1'b0;
    bus_req_i   = 1'b0;
    bus_cmd_i   = '0;
    debug_req_i = 1'b1;
    exp_cmp     = '1;
    rtc_edges   = 0;
    ack_prev    = 1'b0;
    req_prev    = 1'b0;
    rsp_held    = '0;
    bad_addr    = '{16'h0020, 16'h0800, 16'h1100, 16'h2002,
                    16'h2008, 16'h200c, 16'h3000, 16'hfffc};
    repeat (10) @(posedge clk_i);
    ndmreset_n <= 1'b1;
    check_rsp('0, bus_rsp_o, "response after reset");
    check_bit(1'b0, bus_ack_o, "ack after reset");
    check_bit(1'b0, timer_irq_o, "timer irq after reset");

    // debug hold-off with 2 cycles of margin on each side
    for (int k = 1; k <= 48; k++) begin
      @(posedge clk_i);
      if (k <= 38)
        check_bit(1'b0, debug_req_o, "debug request during hold-off");
      if (k >= 42)
        check_bit(1'b1, debug_req_o, "debug request after hold-off");
    end

    // boot ROM
    for (int w = 0; w < 8; w++)
      bus_access(1'b0, 16'(w * 4), '0, '0);
    bus_access(1'b1, 16'h0008, rand_bits(32), 4'hf);
    bus_access(1'b0, 16'h0008, '0, '0);

    // RAM fill and then random strobed writes mixed with reads
    for (int w = 0; w < 64; w++) begin
      addr = soc_pkg::RAM_BASE + 16'(w * 4);
      bus_access(1'b1, addr, {~addr, addr}, 4'hf);
    end
    for (int i = 0; i < 200; i++) begin
      addr = soc_pkg::RAM_BASE + {8'h0, 6'(rand_bits(6)), 2'b00};
      bus_access(1'b1, addr, rand_bits(32), 4'(rand_bits(4)));
      if (rand_bits(1) == 32'd1) begin
        addr = soc_pkg::RAM_BASE + {8'h0, 6'(rand_bits(6)), 2'b00};
        bus_access(1'b0, addr, '0, '0);
      end
    end

    // unmapped addresses, bad timer offsets and the read-only mtime
    for (int i = 0; i < 8; i++) begin
      bus_access(1'b1, bad_addr[i], rand_bits(32), 4'hf);
      bus_access(1'b0, bad_addr[i], '0, '0);
    end
    bus_access(1'b1, 16'h2000, rand_bits(32), 4'hf);
    bus_access(1'b0, 16'h0000, '0, '0);
    for (int w = 0; w < 64; w++)
      bus_access(1'b0, soc_pkg::RAM_BASE + 16'(w * 4), '0, '0);
    bus_access(1'b0, 16'h2000, '0, '0);
    bus_access(1'b0, 16'h2004, '0, '0);

    // an even edge count leaves the timer divider at zero
    n = 2 + 2 * int'(rand_bits(2));
    repeat (n) rtc_cycle();
    repeat (4) @(posedge clk_i);
    bus_access(1'b0, 16'h2000, '0, '0);
    bus_access(1'b1, 16'h2004, soc_pkg::data_t'(rtc_edges / 2 + 3), 4'(rand_bits(4)));
    bus_access(1'b0, 16'h2004, '0, '0);
    repeat (5) rtc_cycle();
    @(posedge clk_i);
    rtc_i <= 1'b1;
    rtc_edges++;
    // sync, edge detect, count and irq register
    t = 0;
    while (timer_irq_o !== 1'b1) begin
      @(posedge clk_i);
      t++;
      if (t > 5) begin
        $display("timeout: timer irq did not rise after compare match");
        stop_run();
      end
    end
    @(posedge clk_i);
    rtc_i <= 1'b0;
    repeat (4) @(posedge clk_i);
    bus_access(1'b0, 16'h2000, '0, '0);
    check_bit(1'b1, timer_irq_o, "timer irq stays high");

    if (exp_q.size() != 0) begin
      $display("responses still outstanding at end of test");
      stop_run();
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule
